// File: Makefile
# Verilator build and run for the GPIO bus slave testbench

SIM := obj_dir/Vgpio_bus_slave_tb

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM): all.f $(wildcard verilog/*.sv verilog/*.svh test/*.sv test/*.svh)
	verilator --binary --timing -Wno-fatal \
		-f all.f --top-module gpio_bus_slave_tb -o Vgpio_bus_slave_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" sim.log || \
		(echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+verilog
+incdir+test
verilog/gpio_bus_pkg.sv
verilog/gpio_addr_decode.sv
verilog/bus_slave_ctrl.sv
verilog/gpo_register_bank.sv
verilog/gpi_sampler.sv
verilog/gpio_bus_slave.sv
test/gpio_bus_slave_tb.sv

// File: test/gpio_bus_tests.svh
`ifndef GPIO_BUS_TESTS_SVH
`define GPIO_BUS_TESTS_SVH

//////////////////////////////
// address helpers
//////////////////////////////

function automatic gpio_bus_pkg::addr_t gpo_addr(input int idx);
	return gpio_bus_pkg::addr_t'(`GPIO_BASE_ADDR + idx * 4);
endfunction

function automatic gpio_bus_pkg::addr_t gpi_addr(input int idx);
	return gpio_bus_pkg::addr_t'(`GPIO_BASE_ADDR + `GPIO_GPI_OFFSET + idx * 4);
endfunction

// full gp_op as the written words say
function automatic gpio_bus_pkg::gpio_vec_t expected_gp_op();
	gpio_bus_pkg::gpio_vec_t v;
	for (int i = 0; i < `GPIO_WORDS; i++) begin
		v[i*`GPIO_WORD_W +: `GPIO_WORD_W] = gpo_model[i];
	end
	return v;
endfunction

//////////////////////////////
// directed tests
//////////////////////////////

task automatic check_reset_state();
	compare_values("ready", gpio_bus_pkg::gpio_vec_t'(ready), '0);
	compare_values("rsp.error", gpio_bus_pkg::gpio_vec_t'(rsp.error), '0);
	compare_values("rsp.rdata", gpio_bus_pkg::gpio_vec_t'(rsp.rdata), '0);
	compare_values("gp_op_valid", gpio_bus_pkg::gpio_vec_t'(gp_op_valid), '0);
	compare_values("gp_op", gp_op, '0);
endtask

task automatic output_write_readback();
	gpio_bus_pkg::word_t wdata;
	gpio_bus_pkg::word_t rdata;
	gpio_bus_pkg::word_strb_t strb;
	logic err;
	int cycles;
	for (int i = 0; i < `GPIO_WORDS; i++) begin
		wdata = random_word();
		bus_write(gpo_addr(i), wdata, err, strb, cycles);
		compare_values($sformatf("write %0d rsp.error", i), gpio_bus_pkg::gpio_vec_t'(err), '0);
		gpo_model[i] = wdata;
	end
	for (int i = 0; i < `GPIO_WORDS; i++) begin // pins first
		compare_values($sformatf("gp_op word %0d", i),
			gpio_bus_pkg::gpio_vec_t'(gp_op[i*`GPIO_WORD_W +: `GPIO_WORD_W]),
			gpio_bus_pkg::gpio_vec_t'(gpo_model[i]));
	end
	for (int i = 0; i < `GPIO_WORDS; i++) begin // then read-back
		bus_read(gpo_addr(i), rdata, err, cycles);
		compare_values($sformatf("read %0d rsp.rdata", i), gpio_bus_pkg::gpio_vec_t'(rdata),
			gpio_bus_pkg::gpio_vec_t'(gpo_model[i]));
		compare_values($sformatf("read %0d rsp.error", i), gpio_bus_pkg::gpio_vec_t'(err), '0);
	end
endtask

task automatic write_read_timing();
	gpio_bus_pkg::word_t wdata;
	gpio_bus_pkg::word_t rdata;
	gpio_bus_pkg::word_strb_t strb;
	gpio_bus_pkg::word_strb_t strb_exp;
	logic err;
	int cycles;
	int idx;
	for (int n = 0; n < 4; n++) begin
		idx = random_word() % `GPIO_WORDS;
		wdata = random_word();
		strb_exp = '0;
		strb_exp[idx] = 1'b1; // only the addressed word
		bus_write(gpo_addr(idx), wdata, err, strb, cycles);
		gpo_model[idx] = wdata;
		compare_values("write ready latency", gpio_bus_pkg::gpio_vec_t'(cycles),
			gpio_bus_pkg::gpio_vec_t'(`GPIO_WRITE_WAITS + 1)); // ready after E+2
		compare_values("gp_op_valid at ready", gpio_bus_pkg::gpio_vec_t'(strb),
			gpio_bus_pkg::gpio_vec_t'(strb_exp));
		compare_values("gp_op_valid after ready", gpio_bus_pkg::gpio_vec_t'(gp_op_valid), '0);
		compare_values("gp_op", gp_op, expected_gp_op()); // holds new value
		bus_read(gpo_addr(idx), rdata, err, cycles);
		compare_values("read ready latency", gpio_bus_pkg::gpio_vec_t'(cycles),
			gpio_bus_pkg::gpio_vec_t'(`GPIO_READ_WAITS + 1)); // ready after E+3
		compare_values("rsp.rdata", gpio_bus_pkg::gpio_vec_t'(rdata),
			gpio_bus_pkg::gpio_vec_t'(wdata));
	end
endtask

task automatic input_word_reads();
	gpio_bus_pkg::gpio_vec_t ip_vec;
	gpio_bus_pkg::word_t rdata;
	logic err;
	int cycles;
	for (int i = 0; i < `GPIO_WORDS; i++) begin
		ip_vec[i*`GPIO_WORD_W +: `GPIO_WORD_W] = random_word();
	end
	@(posedge BUS_agnt_vi);
	#DRIVE_DELAY;
	gp_ip = ip_vec;
	repeat (5) @(posedge BUS_agnt_vi); // through the synchronizer
	#DRIVE_DELAY;
	for (int i = 0; i < `GPIO_WORDS; i++) begin
		bus_read(gpi_addr(i), rdata, err, cycles);
		compare_values($sformatf("input word %0d", i), gpio_bus_pkg::gpio_vec_t'(rdata),
			gpio_bus_pkg::gpio_vec_t'(ip_vec[i*`GPIO_WORD_W +: `GPIO_WORD_W]));
		compare_values($sformatf("input %0d rsp.error", i), gpio_bus_pkg::gpio_vec_t'(err), '0);
	end
endtask

task automatic illegal_access_errors();
	gpio_bus_pkg::word_t rdata;
	gpio_bus_pkg::word_strb_t strb;
	logic err;
	int cycles;
	bus_write(32'h0100_0020, random_word(), err, strb, cycles); // read-only range
	compare_values("gpi write rsp.error", gpio_bus_pkg::gpio_vec_t'(err), 1);
	compare_values("gpi write gp_op_valid", gpio_bus_pkg::gpio_vec_t'(strb), '0);
	compare_values("gpi write gp_op_valid after", gpio_bus_pkg::gpio_vec_t'(gp_op_valid), '0);
	bus_read(32'h0100_0040, rdata, err, cycles); // past the window
	compare_values("window read rsp.error", gpio_bus_pkg::gpio_vec_t'(err), 1);
	compare_values("window read rsp.rdata", gpio_bus_pkg::gpio_vec_t'(rdata), '0);
	bus_write(32'h0200_0000, random_word(), err, strb, cycles); // other base
	compare_values("far write rsp.error", gpio_bus_pkg::gpio_vec_t'(err), 1);
	compare_values("far write gp_op_valid", gpio_bus_pkg::gpio_vec_t'(strb), '0);
	compare_values("far write gp_op_valid after", gpio_bus_pkg::gpio_vec_t'(gp_op_valid), '0);
	bus_read(32'h0100_0002, rdata, err, cycles); // unaligned
	compare_values("unaligned read rsp.error", gpio_bus_pkg::gpio_vec_t'(err), 1);
	compare_values("unaligned read rsp.rdata", gpio_bus_pkg::gpio_vec_t'(rdata), '0);
	compare_values("gp_op after errors", gp_op, expected_gp_op()); // no word may move
endtask

`endif

// File: test/gpio_bus_slave_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpio_bus_macros.svh"

module gpio_bus_slave_tb;

	localparam int CLK_PERIOD = 10; // ns
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY = 1; // ns after the rising edge
	localparam int READY_TIMEOUT = 20; // cycles per access

	logic BUS_agnt_vi;
	logic rst_n;
	logic valid;
	gpio_bus_pkg::bus_req_t req;
	logic ready;
	gpio_bus_pkg::bus_rsp_t rsp;
	gpio_bus_pkg::gpio_vec_t gp_ip;
	gpio_bus_pkg::gpio_vec_t gp_op;
	gpio_bus_pkg::word_strb_t gp_op_valid;

	int seed;
	int check_count;
	int error_count;

	// output words as the tb wrote them
	gpio_bus_pkg::word_t gpo_model [`GPIO_WORDS];

	gpio_bus_slave gpio_bus_slave_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n (rst_n),
		.valid (valid),
		.req (req),
		.ready (ready),
		.rsp (rsp),
		.gp_ip (gp_ip),
		.gp_op (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	//////////////////////////////
	// clock
	//////////////////////////////

	initial begin
		BUS_agnt_vi = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) BUS_agnt_vi = ~BUS_agnt_vi;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic compare_values(input string name, input gpio_bus_pkg::gpio_vec_t actual,
		input gpio_bus_pkg::gpio_vec_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected,
				$time);
		end
	endtask

	function automatic gpio_bus_pkg::word_t random_word();
		return $random(seed);
	endfunction

	// one request, waits for the ready pulse, then one idle cycle
	task automatic bus_access(input gpio_bus_pkg::addr_t addr, input gpio_bus_pkg::word_t wdata,
		input logic rnw, output gpio_bus_pkg::bus_rsp_t resp, output int cycles,
		output gpio_bus_pkg::word_strb_t strb);
		bit got_ready;
		got_ready = 1'b0;
		cycles = 0;
		resp = '0;
		strb = '0;
		@(posedge BUS_agnt_vi);
		#DRIVE_DELAY;
		req.addr = addr;
		req.wdata = wdata;
		req.rnw = rnw;
		valid = 1'b1;
		while (!got_ready && cycles < READY_TIMEOUT) begin
			@(posedge BUS_agnt_vi);
			#DRIVE_DELAY;
			cycles++; // edges since valid went high
			if (ready) begin
				got_ready = 1'b1;
				resp = rsp; // stable until the next edge
				strb = gp_op_valid;
			end
		end
		valid = 1'b0; // drop right after ready
		req = '0;
		if (!got_ready) begin
			error_count++;
			$display("bus access to 0x%08h got no ready within %0d cycles", addr,
				READY_TIMEOUT);
		end
		@(posedge BUS_agnt_vi); // valid low for a cycle
		#DRIVE_DELAY;
	endtask

	task automatic bus_write(input gpio_bus_pkg::addr_t addr, input gpio_bus_pkg::word_t wdata,
		output logic err, output gpio_bus_pkg::word_strb_t strb, output int cycles);
		gpio_bus_pkg::bus_rsp_t resp;
		bus_access(addr, wdata, 1'b0, resp, cycles, strb);
		err = resp.error;
	endtask

	task automatic bus_read(input gpio_bus_pkg::addr_t addr, output gpio_bus_pkg::word_t rdata,
		output logic err, output int cycles);
		gpio_bus_pkg::bus_rsp_t resp;
		gpio_bus_pkg::word_strb_t strb;
		bus_access(addr, '0, 1'b1, resp, cycles, strb);
		rdata = resp.rdata;
		err = resp.error;
	endtask

	`include "gpio_bus_tests.svh"

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		seed = 32'hc0e3_4384;
		check_count = 0;
		error_count = 0;
		rst_n = 1'b0;
		valid = 1'b0;
		req = '0;
		gp_ip = '0;
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			gpo_model[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge BUS_agnt_vi);
		#DRIVE_DELAY;
		check_reset_state(); // still in reset here
		rst_n = 1'b1;
		output_write_readback();
		write_read_timing();
		input_word_reads();
		illegal_access_errors();
		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/bus_slave_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpio_bus_macros.svh"

module bus_slave_ctrl (
	input wire logic BUS_agnt_vi,
	input wire logic rst_n,
	input wire logic valid,
	input wire logic rnw,
	input wire gpio_bus_pkg::region_e region,
	input wire gpio_bus_pkg::word_t gpo_word,
	input wire gpio_bus_pkg::word_t gpi_word,
	output logic commit,
	output logic ready,
	output gpio_bus_pkg::bus_rsp_t rsp
);

	gpio_bus_pkg::ctrl_state_e state;
	logic [1:0] wait_cnt; // wait states seen so far
	logic last_wait; // response edge is next
	logic is_error;
	gpio_bus_pkg::word_t rd_sel; // read data to register

	//////////////////////////////
	// wait state count
	//////////////////////////////

	// count target follows the access type
	always_comb begin
		if (rnw) begin
			last_wait = (wait_cnt == 2'(`GPIO_READ_WAITS - 1));
		end else begin
			last_wait = (wait_cnt == 2'(`GPIO_WRITE_WAITS - 1));
		end
	end

	assign is_error = (region == gpio_bus_pkg::region_illegal);

	// read mux, zero on error and on writes
	always_comb begin
		rd_sel = '0;
		if (rnw && !is_error) begin
			if (region == gpio_bus_pkg::region_gpo) begin
				rd_sel = gpo_word; // output read-back
			end else begin
				rd_sel = gpi_word; // synced input
			end
		end
	end

	// bank stores on the same edge ready goes out
	assign commit = (state == gpio_bus_pkg::st_wait) && last_wait && !rnw &&
		(region == gpio_bus_pkg::region_gpo);

	//////////////////////////////
	// handshake fsm
	//////////////////////////////

	always_ff @(posedge BUS_agnt_vi or negedge rst_n) begin
		if (!rst_n) begin
			state <= gpio_bus_pkg::st_idle;
			wait_cnt <= '0;
			ready <= 1'b0;
			rsp <= '0;
		end else begin
			case (state)
				gpio_bus_pkg::st_idle: begin
					if (valid) begin // edge E
						state <= gpio_bus_pkg::st_wait;
						wait_cnt <= '0;
					end
				end
				gpio_bus_pkg::st_wait: begin
					if (last_wait) begin // response edge
						state <= gpio_bus_pkg::st_respond;
						ready <= 1'b1;
						rsp.error <= is_error;
						rsp.rdata <= rd_sel;
					end else begin
						wait_cnt <= wait_cnt + 2'd1;
					end
				end
				gpio_bus_pkg::st_respond: begin
					// requester always takes the response, valid not checked
					state <= gpio_bus_pkg::st_idle;
					ready <= 1'b0; // one cycle pulse
					rsp <= '0;
				end
				default: begin
					state <= gpio_bus_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/gpi_sampler.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpio_bus_macros.svh"

module gpi_sampler (
	input wire logic BUS_agnt_vi,
	input wire logic rst_n,
	input wire gpio_bus_pkg::gpio_vec_t gp_ip,
	input wire gpio_bus_pkg::word_idx_t word_idx,
	output gpio_bus_pkg::word_t rd_word
);

	gpio_bus_pkg::gpio_vec_t sync_q1; // first stage, may go metastable
	gpio_bus_pkg::gpio_vec_t sync_q2; // safe to use

	//////////////////////////////
	// two flop synchronizer
	//////////////////////////////

	always_ff @(posedge BUS_agnt_vi or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= gp_ip; // async pins in
			sync_q2 <= sync_q1;
		end
	end

	// word select, two cycles behind the pins
	assign rd_word = sync_q2[word_idx*`GPIO_WORD_W +: `GPIO_WORD_W];

endmodule

`default_nettype wire

// File: verilog/gpio_addr_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpio_bus_macros.svh"

module gpio_addr_decode (
	input wire gpio_bus_pkg::bus_req_t req,
	output gpio_bus_pkg::region_e region,
	output gpio_bus_pkg::word_idx_t word_idx
);

	// bytes covered by one range
	localparam int RANGE_BYTES = `GPIO_WORDS * (`GPIO_WORD_W / 8);

	gpio_bus_pkg::addr_t offset; // byte offset into the window
	logic aligned;
	logic in_gpo;
	logic in_gpi;

	// below base wraps to a huge offset, lands in illegal
	assign offset = req.addr - `GPIO_BASE_ADDR;

	assign aligned = (offset[1:0] == 2'b00); // word accesses only
	assign in_gpo = (offset < RANGE_BYTES);
	assign in_gpi = (offset >= `GPIO_GPI_OFFSET) &&
		(offset < `GPIO_GPI_OFFSET + RANGE_BYTES);

	// both ranges 32 byte aligned, same bits give the word
	assign word_idx = offset[2 +: $bits(gpio_bus_pkg::word_idx_t)];

	//////////////////////////////
	// region select
	//////////////////////////////

	always_comb begin
		region = gpio_bus_pkg::region_illegal; // default is error
		if (aligned) begin
			if (in_gpo) begin
				region = gpio_bus_pkg::region_gpo;
			end else if (in_gpi && req.rnw) begin
				// input words never take a write
				region = gpio_bus_pkg::region_gpi;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/gpio_bus_macros.svh
`ifndef GPIO_BUS_MACROS_SVH
`define GPIO_BUS_MACROS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

`define GPIO_ADDR_W 32 // byte address
`define GPIO_WORD_W 32 // data word

// words per direction, gp_op and gp_ip each
`define GPIO_WORDS 8

//////////////////////////////
// address map
//////////////////////////////

// window base, output words start here
`define GPIO_BASE_ADDR 32'h0100_0000

// input words, read only
`define GPIO_GPI_OFFSET 32'h0000_0020

//////////////////////////////
// access timing
//////////////////////////////

`define GPIO_WRITE_WAITS 2 // ready after E+2
`define GPIO_READ_WAITS 3 // ready after E+3

`endif

// File: verilog/gpio_bus_pkg.sv
`default_nettype none

`include "gpio_bus_macros.svh"

package gpio_bus_pkg;

	//////////////////////////////
	// vectors
	//////////////////////////////

	typedef logic [`GPIO_ADDR_W-1:0] addr_t; // byte address
	typedef logic [`GPIO_WORD_W-1:0] word_t; // one data word

	// word number inside one range
	typedef logic [$clog2(`GPIO_WORDS)-1:0] word_idx_t;

	// whole gp_op / gp_ip vector
	typedef logic [`GPIO_WORDS*`GPIO_WORD_W-1:0] gpio_vec_t;

	typedef logic [`GPIO_WORDS-1:0] word_strb_t; // per word update pulse

	//////////////////////////////
	// enums
	//////////////////////////////

	// decoded target of an access
	typedef enum logic [1:0] {
		region_gpo, // output words, read/write
		region_gpi, // input words, read only
		region_illegal // bus error
	} region_e;

	// slave handshake fsm
	typedef enum logic [1:0] {
		st_idle,
		st_wait, // counting wait states
		st_respond // ready pulse out
	} ctrl_state_e;

	//////////////////////////////
	// bus payloads
	//////////////////////////////

	// request side, held stable while valid is high
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic rnw; // 1 = read
	} bus_req_t;

	// response side, valid with ready
	typedef struct packed {
		word_t rdata;
		logic error;
	} bus_rsp_t;

endpackage

`default_nettype wire

// File: verilog/gpio_bus_slave.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_bus_slave (
	input wire logic BUS_agnt_vi,
	input wire logic rst_n,
	input wire logic valid,
	input wire gpio_bus_pkg::bus_req_t req,
	output logic ready,
	output gpio_bus_pkg::bus_rsp_t rsp,
	input wire gpio_bus_pkg::gpio_vec_t gp_ip,
	output gpio_bus_pkg::gpio_vec_t gp_op,
	output gpio_bus_pkg::word_strb_t gp_op_valid
);

	gpio_bus_pkg::region_e region; // decoded target
	gpio_bus_pkg::word_idx_t word_idx;
	logic commit; // legal write lands
	gpio_bus_pkg::word_t gpo_word; // output read-back
	gpio_bus_pkg::word_t gpi_word; // synced input word

	//////////////////////////////
	// address decode
	//////////////////////////////

	gpio_addr_decode gpio_addr_decode_inst (
		.req (req),
		.region (region),
		.word_idx (word_idx)
	);

	//////////////////////////////
	// bus handshake
	//////////////////////////////

	bus_slave_ctrl bus_slave_ctrl_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n (rst_n),
		.valid (valid),
		.rnw (req.rnw),
		.region (region),
		.gpo_word (gpo_word),
		.gpi_word (gpi_word),
		.commit (commit),
		.ready (ready),
		.rsp (rsp)
	);

	//////////////////////////////
	// gpio side
	//////////////////////////////

	gpo_register_bank gpo_register_bank_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n (rst_n),
		.commit (commit),
		.word_idx (word_idx),
		.wdata (req.wdata), // held stable until ready
		.gp_op (gp_op),
		.gp_op_valid (gp_op_valid),
		.rd_word (gpo_word)
	);

	gpi_sampler gpi_sampler_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n (rst_n),
		.gp_ip (gp_ip),
		.word_idx (word_idx),
		.rd_word (gpi_word)
	);

endmodule

`default_nettype wire

// File: verilog/gpo_register_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpio_bus_macros.svh"

module gpo_register_bank (
	input wire logic BUS_agnt_vi,
	input wire logic rst_n,
	input wire logic commit,
	input wire gpio_bus_pkg::word_idx_t word_idx,
	input wire gpio_bus_pkg::word_t wdata,
	output gpio_bus_pkg::gpio_vec_t gp_op,
	output gpio_bus_pkg::word_strb_t gp_op_valid,
	output gpio_bus_pkg::word_t rd_word
);

	gpio_bus_pkg::word_strb_t strb_dec; // one hot of word_idx

	assign strb_dec = gpio_bus_pkg::word_strb_t'(1) << word_idx;

	//////////////////////////////
	// output words
	//////////////////////////////

	// gp_op is visible at the pins, so it starts from zero
	always_ff @(posedge BUS_agnt_vi or negedge rst_n) begin
		if (!rst_n) begin
			gp_op <= '0;
		end else if (commit) begin
			gp_op[word_idx*`GPIO_WORD_W +: `GPIO_WORD_W] <= wdata; // only the addressed word
		end
	end

	// update pulse, high for the cycle after commit
	always_ff @(posedge BUS_agnt_vi or negedge rst_n) begin
		if (!rst_n) begin
			gp_op_valid <= '0;
		end else if (commit) begin
			gp_op_valid <= strb_dec;
		end else begin
			gp_op_valid <= '0; // back to zero
		end
	end

	//////////////////////////////
	// read-back
	//////////////////////////////

	assign rd_word = gp_op[word_idx*`GPIO_WORD_W +: `GPIO_WORD_W]; // current value

endmodule

`default_nettype wire
